//--- common/dpa_ctrl_pkg.sv
// ------------------------------------------------
// dpa control package
// album state encoding, copy rhythm constants and
// the control word sent to the pixel buffer
// ------------------------------------------------
`default_nettype none

package dpa_ctrl_pkg;

    // ------------------------------------------------
    // album fsm
    // ------------------------------------------------
    typedef enum logic [1:0] {
        SETUP      = 2'd0,  // read fb base and photo count
        PHOTO_SET  = 2'd1,  // fetch current photo address
        PHOTO_COPY = 2'd2,  // photo into frame buffer
        HOLD       = 2'd3   // idle until frame wrap
    } album_state_e;

    // frame cycle counter
    typedef logic [19:0] frame_cnt_t;

    // frame count where copying begins
    localparam frame_cnt_t COPY_LEAD = 20'd5;

    // ------------------------------------------------
    // copy rhythm
    // ------------------------------------------------
    // phase in the pixel pair, 0 to 4
    typedef logic [2:0] copy_phase_t;

    // 3 reads then 2 writes per pair
    localparam int PAIR_CYCLES = 5;

    typedef struct packed {
        logic        active;  // copy in progress
        copy_phase_t phase;   // position in pair
    } copy_ctl_t;

endpackage : dpa_ctrl_pkg

`default_nettype wire

//--- common/dpa_mem_pkg.sv
// ------------------------------------------------
// dpa memory package
// widths and album header layout as seen at the
// single-port image memory
// ------------------------------------------------
`default_nettype none

package dpa_mem_pkg;

    // ------------------------------------------------
    // word types
    // ------------------------------------------------
    typedef logic [19:0] im_addr_t;    // image memory word address
    typedef logic [23:0] pixel_t;      // one rgb word
    typedef logic [1:0]  photo_idx_t;  // photo index, up to four photos

    // ------------------------------------------------
    // album header layout
    // ------------------------------------------------
    // word 0 holds the frame buffer base
    localparam im_addr_t HDR_FB_ADDR    = 20'd0;
    // word 1 holds photo count minus one in bits [1:0]
    localparam im_addr_t HDR_PHOTO_NUM  = 20'd1;
    // photo p start address at base + 2p
    // the odd word after it is the size word, never read here
    localparam im_addr_t HDR_PHOTO_BASE = 20'd2;

endpackage : dpa_mem_pkg

`default_nettype wire

//--- dv/dpa_tb.sv
// ------------------------------------------------
// dpa testbench
// image memory model, table of album cases and a
// cycle monitor for addresses, writes and data
// ------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module dpa_tb;

    import dpa_mem_pkg::*;

    localparam int FRAME_CYCLES = 64;
    localparam int PHOTO_PIXELS = 16;
    localparam int MEM_WORDS    = 4096;  // model covers 12 address bits
    localparam int NUM_CASES    = 3;
    localparam int HDR_BASE     = 2;     // photo p address word at 2 + 2p
    localparam int COPY_START   = 5;     // frame count of first pair read
    localparam int PAIR_LEN     = 5;     // 3 reads, 2 writes
    localparam int COPY_END     = COPY_START + PAIR_LEN * PHOTO_PIXELS / 2;

    typedef struct packed {
        logic [11:0]      fb;      // frame buffer base
        logic [2:0]       count;   // photos, 1 to 4
        logic [3:0][11:0] photo;   // start addresses, photo 0 lowest
        logic [3:0]       frames;  // frames to run
    } album_case_t;

    wire         clk;
    wire         reset;
    pixel_t      im_q;
    im_addr_t    im_a;
    wire         im_wen_n;
    pixel_t      im_d;

    pixel_t      mem [MEM_WORDS];
    logic [11:0] rd_addr;                    // address of last cycle
    pixel_t      photo_px [4][PHOTO_PIXELS]; // expected photo contents
    album_case_t album_table [NUM_CASES];
    album_case_t cur;
    int          case_idx;
    logic        running;
    int          cyc;                        // cycles since reset release
    int          wr_cnt;
    int          checks;
    int          mismatches;
    int          other_errors;
    int          seed_dummy;

    tb_clock_gen #(.PERIOD_NS(100), .RESET_CYCLES(16)) clk_gen (.clk(clk), .reset(reset));

    dpa_top #(
        .FRAME_CYCLES (FRAME_CYCLES),
        .PHOTO_PIXELS (PHOTO_PIXELS)
    ) UUT (
        .clk      (clk),
        .reset    (reset),
        .im_q     (im_q),
        .im_a     (im_a),
        .im_wen_n (im_wen_n),
        .im_d     (im_d)
    );

    // ------------------------------------------------
    // synchronous image memory
    // ------------------------------------------------
    always @(posedge clk) begin
        if (!im_wen_n) begin
            mem[im_a[11:0]] <= im_d;
        end
        rd_addr <= im_a[11:0];
    end

    always @(negedge clk) begin
        im_q <= mem[rd_addr];  // word of previous address
    end

    task automatic compare_value(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            mismatches++;
            $display("MISMATCH %s expected %0h actual %0h", name, expected, actual);
        end
    endtask

    // ------------------------------------------------
    // per cycle monitor, sampled mid cycle
    // ------------------------------------------------
    always @(negedge clk) begin : cycle_monitor
        int          n;
        int          f;
        int          p;
        int          k;
        int          ph;
        logic [31:0] exp_a;
        logic        exp_wen;
        string       tag;
        if (reset) begin
            compare_value("reset im_wen_n", 1, im_wen_n);
            compare_value("reset im_a", 0, im_a);
        end
        if (reset || !running) begin
            cyc    <= 1;  // next sample is frame count 1
            wr_cnt <= 0;
        end else begin
            n       = cyc % FRAME_CYCLES;
            f       = cyc / FRAME_CYCLES;
            p       = f % cur.count;  // photo on show
            tag     = $sformatf("case%0d frame%0d n%0d", case_idx, f, n);
            exp_a   = HDR_BASE + 2 * p;  // header word outside the copy
            exp_wen = 1'b1;
            ph      = -1;
            if (f == 0 && n < 3) begin
                exp_a = n;  // setup walks words 0, 1, 2
            end
            if (n >= COPY_START && n < COPY_END) begin
                k  = (n - COPY_START) / PAIR_LEN;
                ph = (n - COPY_START) % PAIR_LEN;
                case (ph)
                    0:       exp_a = cur.photo[p] + 2 * k;
                    1, 2:    exp_a = cur.photo[p] + 2 * k + 1;  // odd read held
                    3:       exp_a = cur.fb + 2 * k;
                    default: exp_a = cur.fb + 2 * k + 1;
                endcase
                exp_wen = (ph < 3);  // writes in last two phases
            end
            compare_value({tag, " im_a"}, exp_a, im_a);
            compare_value({tag, " im_wen_n"}, exp_wen, im_wen_n);
            if (ph >= 3) begin
                compare_value({tag, " im_d"}, photo_px[p][2 * k + ph - 3], im_d);
            end
            if (n == FRAME_CYCLES - 1) begin
                compare_value({tag, " writes per frame"}, PHOTO_PIXELS, wr_cnt);
                wr_cnt <= 0;
            end else if (!im_wen_n) begin
                wr_cnt <= wr_cnt + 1;
            end
            cyc <= cyc + 1;
        end
    end

    // header, random photos, fill pattern elsewhere
    task load_album;
        int a;
        int p;
        int i;
        for (a = 0; a < MEM_WORDS; a++) begin
            mem[a] = {12'hA5C, a[11:0]};
        end
        mem[0] = pixel_t'(cur.fb);
        mem[1] = pixel_t'(cur.count - 1);  // count minus one
        for (p = 0; p < cur.count; p++) begin
            mem[HDR_BASE + 2 * p] = pixel_t'(cur.photo[p]);
            for (i = 0; i < PHOTO_PIXELS; i++) begin
                photo_px[p][i] = pixel_t'($urandom);
                mem[cur.photo[p] + i] = photo_px[p][i];
            end
        end
    endtask

    task wait_first_write(input int fr);
        int t;
        t = 0;
        while (im_wen_n === 1'b1 && t < FRAME_CYCLES) begin
            @(negedge clk);
            t++;
        end
        if (im_wen_n !== 1'b0) begin
            other_errors++;
            $display("timeout: case %0d frame %0d made no frame buffer write", case_idx, fr);
        end
    endtask

    task wait_frame_end(input int fr);
        int t;
        t = 0;
        while ((cyc % FRAME_CYCLES) != FRAME_CYCLES - 1 && t < FRAME_CYCLES) begin
            @(negedge clk);
            t++;
        end
        if ((cyc % FRAME_CYCLES) != FRAME_CYCLES - 1) begin
            other_errors++;
            $display("timeout: case %0d frame %0d never reached its last cycle", case_idx, fr);
        end
    endtask

    task check_frame_buffer(input int fr);
        int p;
        int i;
        p = fr % cur.count;
        for (i = 0; i < PHOTO_PIXELS; i++) begin
            compare_value($sformatf("case%0d frame%0d fb[%0d]", case_idx, fr, i),
                          photo_px[p][i], mem[cur.fb + i]);
        end
    endtask

    task finish_run;
        $display("checks %0d, mismatches %0d, other errors %0d",
                 checks, mismatches, other_errors);
        if (mismatches == 0 && other_errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    endtask

    // ------------------------------------------------
    // album cases
    // ------------------------------------------------
    initial begin : main
        int ci;
        int fr;
        im_q         = '0;
        rd_addr      = '0;
        running      = 1'b0;
        checks       = 0;
        mismatches   = 0;
        other_errors = 0;
        case_idx     = 0;
        cur          = '0;
        seed_dummy   = $urandom(32'h4ebe);  // seed once
        // fb base, photo count, photo 3..0 addresses, frames
        album_table[0] = {12'h100, 3'd1, {12'h000, 12'h000, 12'h000, 12'h040}, 4'd3};
        album_table[1] = {12'h200, 3'd4, {12'h0A0, 12'h080, 12'h060, 12'h040}, 4'd6};
        album_table[2] = {12'h7F0, 3'd2, {12'h000, 12'h000, 12'h5E0, 12'h300}, 4'd3};
        for (ci = 0; ci < NUM_CASES && other_errors == 0; ci++) begin
            @(posedge clk);  // away from the monitor edge
            case_idx = ci;
            cur      = album_table[ci];
            load_album();
            clk_gen.apply_reset();
            running <= 1'b1;
            for (fr = 0; fr < cur.frames && other_errors == 0; fr++) begin
                wait_first_write(fr);
                wait_frame_end(fr);
                check_frame_buffer(fr);
            end
            running <= 1'b0;
        end
        @(posedge clk);  // let the last monitor sample settle
        finish_run();
    end

endmodule : dpa_tb

`default_nettype wire

//--- dv/tb_clock_gen.sv
// ------------------------------------------------
// testbench clock and reset
// free running clock, reset held for a set number
// of cycles and released on a falling edge
// ------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS    = 100,  // clock period
    parameter int RESET_CYCLES = 16    // reset length in cycles
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk   = 1'b0;
        reset = 1'b1;  // held from time zero
    end

    always #(PERIOD_NS / 2) clk = ~clk;

    // assert, count cycles, release on a falling edge
    task apply_reset;
        @(negedge clk);
        reset <= 1'b1;
        repeat (RESET_CYCLES) @(negedge clk);
        reset <= 1'b0;
    endtask

endmodule : tb_clock_gen

`default_nettype wire

//--- hw/album_sequencer.sv
// ------------------------------------------------
// album sequencer
// frame timer and album fsm. reads the header,
// hands each photo to the copy engine and steps
// to the next photo when the frame wraps
// ------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module album_sequencer #(
    parameter int FRAME_CYCLES = 1_000_000  // cycles per frame
) (
    input  wire                       clk,
    input  wire                       reset,
    input  wire dpa_mem_pkg::pixel_t  im_q,       // read data, one cycle behind im_a
    input  wire                       copy_done,  // last copy cycle
    output logic                      start,      // kick the copy engine
    output dpa_mem_pkg::im_addr_t     src_base,   // current photo start
    output dpa_mem_pkg::im_addr_t     dst_base,   // frame buffer base
    output dpa_mem_pkg::im_addr_t     hdr_addr    // header read address
);

    import dpa_mem_pkg::*;
    import dpa_ctrl_pkg::*;

    // ------------------------------------------------
    // frame count landmarks
    // ------------------------------------------------
    localparam frame_cnt_t LAST_CNT    = frame_cnt_t'(FRAME_CYCLES - 1);
    // header word shows on im_q one count after its address
    localparam frame_cnt_t FB_CAP_CNT  = frame_cnt_t'(HDR_FB_ADDR + 1'b1);
    localparam frame_cnt_t NUM_CAP_CNT = frame_cnt_t'(HDR_PHOTO_NUM + 1'b1);
    localparam frame_cnt_t SET_LAST    = COPY_LEAD - 1'b1;  // photo addr arrives here

    frame_cnt_t   frame_cnt;
    logic         frame_wrap;

    album_state_e state;
    album_state_e state_nxt;

    photo_idx_t   photo_idx;   // photo on display
    photo_idx_t   photo_num;   // count minus one from header
    im_addr_t     photo_hdr;   // header word of current photo

    assign frame_wrap = (frame_cnt == LAST_CNT);

    // ------------------------------------------------
    // frame timer
    // ------------------------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            frame_cnt <= '0;
        end else if (frame_wrap) begin
            frame_cnt <= '0;
        end else begin
            frame_cnt <= frame_cnt + 1'b1;
        end
    end

    // ------------------------------------------------
    // album fsm
    // ------------------------------------------------
    always_comb begin
        state_nxt = state;
        case (state)
            SETUP: begin
                if (frame_cnt == NUM_CAP_CNT) begin  // count word in hand
                    state_nxt = PHOTO_SET;
                end
            end
            PHOTO_SET: begin
                if (frame_cnt == SET_LAST) begin
                    state_nxt = PHOTO_COPY;
                end
            end
            PHOTO_COPY: begin
                if (copy_done) begin
                    state_nxt = HOLD;
                end
            end
            HOLD: begin
                if (frame_wrap) begin
                    state_nxt = PHOTO_SET;  // new frame, new photo
                end
            end
            default: state_nxt = SETUP;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= SETUP;
        end else begin
            state <= state_nxt;
        end
    end

    // photo rotation at the wrap
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            photo_idx <= '0;
        end else if (state == HOLD && frame_wrap) begin
            if (photo_idx == photo_num) begin
                photo_idx <= '0;  // back to first photo
            end else begin
                photo_idx <= photo_idx + 1'b1;
            end
        end
    end

    // ------------------------------------------------
    // header capture
    // ------------------------------------------------
    always_ff @(posedge clk) begin
        if (state == SETUP && frame_cnt == FB_CAP_CNT) begin
            dst_base <= im_q[$bits(im_addr_t)-1:0];
        end
        if (state == SETUP && frame_cnt == NUM_CAP_CNT) begin
            photo_num <= im_q[$bits(photo_idx_t)-1:0];  // low bits only
        end
        if (state == PHOTO_SET && frame_cnt == SET_LAST) begin
            src_base <= im_q[$bits(im_addr_t)-1:0];
        end
    end

    // two header words per photo
    assign photo_hdr = HDR_PHOTO_BASE + im_addr_t'({photo_idx, 1'b0});

    // setup walks the header by frame count
    assign hdr_addr = (state == SETUP) ? im_addr_t'(frame_cnt) : photo_hdr;

    assign start = (state == PHOTO_SET) && (frame_cnt == SET_LAST);

    // ------------------------------------------------
    // checks
    // ------------------------------------------------
    // engine finishes only inside the copy window
    assert property (@(posedge clk) disable iff (reset)
        copy_done |-> state == PHOTO_COPY);

    // copy over before the wrap, so hold ends only there
    assert property (@(posedge clk) disable iff (reset)
        frame_wrap |-> state == HOLD);

endmodule : album_sequencer

`default_nettype wire

//--- hw/copy/copy_engine.sv
// ------------------------------------------------
// copy engine
// five cycle pixel pair rhythm. reads two source
// pixels, writes them to the frame buffer and
// owns the memory address and write enable
// ------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module copy_engine #(
    parameter int PHOTO_PIXELS = 65_536  // pixels per photo, even
) (
    input  wire                         clk,
    input  wire                         reset,
    input  wire                         start,      // one cycle kick
    input  wire dpa_mem_pkg::im_addr_t  src_base,
    input  wire dpa_mem_pkg::im_addr_t  dst_base,
    input  wire dpa_mem_pkg::im_addr_t  hdr_addr,   // used while idle
    output dpa_mem_pkg::im_addr_t       im_a,
    output logic                        im_wen_n,
    output logic                        copy_done,
    output dpa_ctrl_pkg::copy_ctl_t     ctl
);

    import dpa_mem_pkg::*;
    import dpa_ctrl_pkg::*;

    localparam copy_phase_t LAST_PHASE = copy_phase_t'(PAIR_CYCLES - 1);
    localparam im_addr_t    LAST_PAIR  = im_addr_t'(PHOTO_PIXELS / 2 - 1);

    // phase numbers of the pair
    localparam copy_phase_t RD_EVEN  = 3'd0;
    localparam copy_phase_t RD_ODD   = 3'd1;
    localparam copy_phase_t RD_HOLD  = 3'd2;  // odd read data in flight
    localparam copy_phase_t WR_EVEN  = 3'd3;

    logic        active;
    copy_phase_t phase;
    im_addr_t    pair_cnt;   // pair k
    im_addr_t    pix_off;    // 2k
    logic        wr_phase;

    // ------------------------------------------------
    // rhythm counters
    // ------------------------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            active   <= 1'b0;
            phase    <= '0;
            pair_cnt <= '0;
        end else if (start) begin
            active   <= 1'b1;
            phase    <= '0;
            pair_cnt <= '0;
        end else if (active) begin
            if (phase == LAST_PHASE) begin
                phase <= '0;
                if (pair_cnt == LAST_PAIR) begin
                    active <= 1'b0;  // photo done
                end else begin
                    pair_cnt <= pair_cnt + 1'b1;
                end
            end else begin
                phase <= phase + 1'b1;
            end
        end
    end

    assign pix_off = {pair_cnt[$bits(im_addr_t)-2:0], 1'b0};

    // ------------------------------------------------
    // memory address
    // ------------------------------------------------
    always_comb begin
        im_a = hdr_addr;  // header reads when idle
        if (active) begin
            case (phase)
                RD_EVEN: im_a = src_base + pix_off;
                RD_ODD,
                RD_HOLD: im_a = src_base + pix_off + 1'b1;  // hold odd address
                WR_EVEN: im_a = dst_base + pix_off;
                default: im_a = dst_base + pix_off + 1'b1;
            endcase
        end
    end

    assign wr_phase  = (phase == WR_EVEN) || (phase == LAST_PHASE);
    assign im_wen_n  = !(active && wr_phase);  // active low

    assign copy_done = active && (phase == LAST_PHASE) && (pair_cnt == LAST_PAIR);

    assign ctl = '{active: active, phase: phase};

    // ------------------------------------------------
    // checks
    // ------------------------------------------------
    // writes stay inside the frame buffer
    assert property (@(posedge clk) disable iff (reset)
        !im_wen_n |-> im_addr_t'(im_a - dst_base) < im_addr_t'(PHOTO_PIXELS));

    // sequencer never restarts a running copy
    assert property (@(posedge clk) disable iff (reset)
        start |-> !active);

endmodule : copy_engine

`default_nettype wire

//--- hw/copy/pixel_buffer.sv
// ------------------------------------------------
// pixel buffer
// holds the two pixels of a pair between the
// memory reads and the frame buffer writes
// ------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module pixel_buffer (
    input  wire                           clk,
    input  wire                           reset,
    input  wire dpa_ctrl_pkg::copy_ctl_t  ctl,
    input  wire dpa_mem_pkg::pixel_t      im_q,
    output dpa_mem_pkg::pixel_t           im_d
);

    import dpa_mem_pkg::*;
    import dpa_ctrl_pkg::*;

    // im_q carries the previous phase's read
    localparam copy_phase_t CAP_EVEN = 3'd1;
    localparam copy_phase_t CAP_ODD  = 3'd2;
    localparam copy_phase_t WR_ODD   = 3'd4;

    pixel_t slot0;  // even pixel
    pixel_t slot1;  // odd pixel

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            slot0 <= '0;
            slot1 <= '0;
        end else if (ctl.active) begin
            if (ctl.phase == CAP_EVEN) begin
                slot0 <= im_q;
            end
            if (ctl.phase == CAP_ODD) begin
                slot1 <= im_q;
            end
        end
    end

    // slot 0 on first write, slot 1 on second
    assign im_d = (ctl.phase == WR_ODD) ? slot1 : slot0;

endmodule : pixel_buffer

`default_nettype wire

//--- hw/dpa_top.sv
// ------------------------------------------------
// dpa top
// photo album display controller on one
// single-port image memory
// ------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module dpa_top #(
    parameter int FRAME_CYCLES = 1_000_000,  // cycles per frame
    parameter int PHOTO_PIXELS = 65_536      // pixels per photo
) (
    input  wire                       clk,
    input  wire                       reset,
    input  wire dpa_mem_pkg::pixel_t  im_q,
    output dpa_mem_pkg::im_addr_t     im_a,
    output logic                      im_wen_n,
    output dpa_mem_pkg::pixel_t       im_d
);

    import dpa_mem_pkg::*;
    import dpa_ctrl_pkg::*;

    // ------------------------------------------------
    // sequencer to engine
    // ------------------------------------------------
    logic      start;
    logic      copy_done;
    im_addr_t  src_base;
    im_addr_t  dst_base;
    im_addr_t  hdr_addr;
    copy_ctl_t ctl;        // engine to buffer

    album_sequencer #(
        .FRAME_CYCLES (FRAME_CYCLES)
    ) u_seq (
        .clk       (clk),
        .reset     (reset),
        .im_q      (im_q),
        .copy_done (copy_done),
        .start     (start),
        .src_base  (src_base),
        .dst_base  (dst_base),
        .hdr_addr  (hdr_addr)
    );

    copy_engine #(
        .PHOTO_PIXELS (PHOTO_PIXELS)
    ) u_copy (
        .clk       (clk),
        .reset     (reset),
        .start     (start),
        .src_base  (src_base),
        .dst_base  (dst_base),
        .hdr_addr  (hdr_addr),
        .im_a      (im_a),
        .im_wen_n  (im_wen_n),
        .copy_done (copy_done),
        .ctl       (ctl)
    );

    pixel_buffer u_pbuf (
        .clk   (clk),
        .reset (reset),
        .ctl   (ctl),
        .im_q  (im_q),
        .im_d  (im_d)
    );

endmodule : dpa_top

`default_nettype wire

//--- sim.f
common/dpa_mem_pkg.sv
common/dpa_ctrl_pkg.sv
hw/album_sequencer.sv
hw/copy/copy_engine.sv
hw/copy/pixel_buffer.sv
hw/dpa_top.sv
dv/tb_clock_gen.sv
dv/dpa_tb.sv
